// File: phy_ctl_top.f
common/phy_ctl_pkg.sv
design/phy_ctl_regs.sv
lmmi/lmmi_reg_port.sv
lmmi/lmmi_rd_collect.sv
design/phy_ctl_top.sv
bench/phy_ctl_sva.sv
bench/phy_ctl_tb.sv

// File: bench/phy_ctl_tb.sv
`timescale 1ns/1ps

module phy_ctl_tb;

	import phy_ctl_pkg::*;

	// 20 ns clock
	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 16;
	localparam int POLL_MAX = 50;
	// Watchdog budget for 80 transfers of up to 70 cycles plus slack
	localparam int WD_CYCLES = RST_CYCLES + 80 * 70 + 400;
	localparam int WR_PER_PORT = 8;

	logic CLK_IN;
	logic RST_IN;
	logic [LB_ADR-1:0] lb_adr;
	logic lb_wr;
	logic lb_rd;
	logic [LB_DAT-1:0] lb_din;
	logic [LB_DAT-1:0] lb_dout;
	logic lb_vld;
	logic [PIO_IN_W-1:0] pio_in;
	logic [PIO_OUT_W-1:0] pio_out;

	// Reference model state
	logic [LMMI_DAT-1:0] ref_mem [LMMI_PORTS][1 << LMMI_ADR];
	logic [PIO_OUT_W-1:0] exp_pio;
	logic [PIO_OUT_W-1:0] exp_msk;
	int errors;

	phy_ctl_top i_dut (
		.CLK_IN(CLK_IN),
		.RST_IN(RST_IN),
		.lb_adr(lb_adr),
		.lb_wr(lb_wr),
		.lb_rd(lb_rd),
		.lb_din(lb_din),
		.lb_dout(lb_dout),
		.lb_vld(lb_vld),
		.pio_in(pio_in),
		.pio_out(pio_out)
	);

	always #(CLK_PERIOD / 2) CLK_IN = ~CLK_IN;

	// Next PIO output for one register write
	function automatic logic [PIO_OUT_W-1:0] ref_pio(input logic [LB_ADR-1:0] op,
		input logic [PIO_OUT_W-1:0] cur, input logic [PIO_OUT_W-1:0] msk,
		input logic [PIO_OUT_W-1:0] dat);
		case (op)
			REG_PIO_SET: return cur | dat;
			REG_PIO_CLR: return cur & ~dat;
			// Only bits enabled in the mask follow the data
			REG_PIO_OUT: return (cur & ~msk) | (dat & msk);
			default: return cur;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h",
				$time, name, got, exp);
			errors++;
		end
	endtask

	// Called at a falling edge and returns at the next one
	task automatic lb_write(input logic [LB_ADR-1:0] adr, input logic [LB_DAT-1:0] dat);
		lb_adr = adr;
		lb_din = dat;
		lb_wr = 1'b1;
		@(negedge CLK_IN);
		lb_wr = 1'b0;
	endtask

	// Data comes one cycle after the strobe is sampled
	task automatic lb_read(input logic [LB_ADR-1:0] adr, output logic [LB_DAT-1:0] dat);
		lb_adr = adr;
		lb_rd = 1'b1;
		@(negedge CLK_IN);
		lb_rd = 1'b0;
		check_val("lb_vld", lb_vld, 1'b1);
		dat = lb_dout;
	endtask

	task automatic poll_idle(input int port);
		logic [LB_DAT-1:0] sta;
		int polls;
		polls = 0;
		sta = '1;
		while (sta[STA_BUSY] && polls < POLL_MAX)
		begin
			lb_read(REG_STA, sta);
			polls++;
		end
		if (sta[STA_BUSY] !== 1'b0)
		begin
			$display("Port %0d still busy after %0d status polls", port, POLL_MAX);
			errors++;
		end
	endtask

	// Load the command word, fire the flag, check busy, wait for idle
	task automatic lmmi_cmd(input int port, input logic [LMMI_ADR-1:0] adr,
		input logic [LMMI_DAT-1:0] dat, input logic wr);
		logic [LB_DAT-1:0] cmd;
		logic [LB_DAT-1:0] sta;
		cmd = '0;
		cmd[CMD_PORT_LSB +: PORT_W] = PORT_W'(port);
		cmd[CMD_ADR_LSB +: LMMI_ADR] = adr;
		cmd[CMD_DAT_LSB +: LMMI_DAT] = dat;
		lb_write(REG_LMMI, cmd);
		lb_write(REG_CTL, wr ? (32'd1 << CTL_WR) : (32'd1 << CTL_RD));
		// Busy shows up one cycle after the flag
		@(negedge CLK_IN);
		lb_read(REG_STA, sta);
		check_val("sta_busy", sta[STA_BUSY], 1);
		poll_idle(port);
	endtask

	task automatic lmmi_read_check(input int port, input logic [LMMI_ADR-1:0] adr);
		logic [LB_DAT-1:0] rd;
		// Clear stale ready while busy stays low
		lb_write(REG_STA, 32'd1 << STA_RDY);
		lb_read(REG_STA, rd);
		check_val("status", rd, 0);
		lmmi_cmd(port, adr, '0, 1'b0);
		lb_read(REG_STA, rd);
		check_val("sta_rdy", rd[STA_RDY], 1);
		lb_read(REG_LMMI, rd);
		check_val("lmmi_rdat", rd, {24'd0, ref_mem[port][adr]});
	endtask

	// One PIO write with the model updated when it lands
	task automatic pio_op(input logic [LB_ADR-1:0] op, input logic [LB_DAT-1:0] dat);
		lb_write(op, dat);
		@(posedge CLK_IN);
		exp_pio = ref_pio(op, exp_pio, exp_msk, dat[PIO_OUT_W-1:0]);
		if (op == REG_PIO_MSK)
			exp_msk = dat[PIO_OUT_W-1:0];
		else if (op == REG_PIO_OUT)
			exp_msk = '1;
		@(negedge CLK_IN);
	endtask

	// PIO output compared every cycle
	always @(negedge CLK_IN)
	begin
		if (!RST_IN)
			check_val("pio_out", pio_out, exp_pio);
	end

	initial
	begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		logic [LB_DAT-1:0] rd;
		logic [LMMI_ADR-1:0] adr;
		logic [LMMI_DAT-1:0] dat;
		logic [PIO_IN_W-1:0] pin;
		logic [LMMI_ADR-1:0] adr_q [$];
		rd = $urandom(40);
		errors = 0;
		exp_pio = '0;
		exp_msk = '0;
		CLK_IN = 1'b0;
		RST_IN = 1'b1;
		lb_adr = '0;
		lb_wr = 1'b0;
		lb_rd = 1'b0;
		lb_din = '0;
		pio_in = '0;
		repeat (RST_CYCLES) @(negedge CLK_IN);
		RST_IN = 1'b0;
		@(negedge CLK_IN);

		// Reset values
		lb_read(REG_STA, rd);
		check_val("status", rd, 0);
		lb_read(REG_CTL, rd);
		check_val("control", rd, 0);
		check_val("pio_out", pio_out, 0);

		// Mask is zero out of reset
		pio_op(REG_PIO_OUT, $urandom);
		check_val("pio_out", pio_out, 0);
		repeat (40)
			pio_op(REG_PIO_SET + LB_ADR'($urandom_range(0, 3)), $urandom);

		// Writes first, then read back every address per port
		for (int p = 0; p < LMMI_PORTS; p++)
		begin
			adr_q.delete();
			for (int n = 0; n < WR_PER_PORT; n++)
			begin
				adr = LMMI_ADR'($urandom_range(0, (1 << LMMI_ADR) - 1));
				dat = LMMI_DAT'($urandom);
				lmmi_cmd(p, adr, dat, 1'b1);
				ref_mem[p][adr] = dat;
				adr_q.push_back(adr);
			end
			foreach (adr_q[k])
				lmmi_read_check(p, adr_q[k]);
		end

		// Parallel input sampled once and then read
		repeat (20)
		begin
			pin = PIO_IN_W'($urandom);
			pio_in = pin;
			@(negedge CLK_IN);
			lb_read(REG_PIO_IN, rd);
			check_val("pio_in readback", rd, {24'd0, pin});
		end

		@(negedge CLK_IN);
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: bench/phy_ctl_sva.sv
`timescale 1ns/1ps

module phy_ctl_sva (
	input logic CLK_IN,
	input logic RST_IN,
	input logic [phy_ctl_pkg::LMMI_PORTS-1:0] lmmi_req,
	input logic [phy_ctl_pkg::LMMI_PORTS-1:0] lmmi_dir,
	input logic [phy_ctl_pkg::LMMI_PORTS-1:0] lmmi_rdy
);

	import phy_ctl_pkg::*;

	// Only the selected port sees a request
	a_req_onehot: assert property (@(posedge CLK_IN) disable iff (RST_IN)
		$onehot0(lmmi_req))
		else $error("More than one LMMI request high");

	// Direction parked low on idle ports
	a_dir_idle: assert property (@(posedge CLK_IN) disable iff (RST_IN)
		(lmmi_dir & ~lmmi_req) == '0)
		else $error("LMMI direction high without request");

	// Request held until that port answers
	for (genvar i = 0; i < LMMI_PORTS; i++)
	begin : gen_hold
		a_req_hold: assert property (@(posedge CLK_IN) disable iff (RST_IN)
			lmmi_req[i] && !lmmi_rdy[i] |=> lmmi_req[i])
			else $error("LMMI request on port %0d dropped before ready", i);
	end

endmodule

bind phy_ctl_top phy_ctl_sva i_sva (
	.CLK_IN(CLK_IN),
	.RST_IN(RST_IN),
	.lmmi_req(lmmi_req),
	.lmmi_dir(lmmi_dir),
	.lmmi_rdy(lmmi_rdy)
);

// File: design/phy_ctl_top.sv
`timescale 1ns/1ps

module phy_ctl_top (
	input logic CLK_IN,
	input logic RST_IN,
	input logic [phy_ctl_pkg::LB_ADR-1:0] lb_adr,
	input logic lb_wr,
	input logic lb_rd,
	input logic [phy_ctl_pkg::LB_DAT-1:0] lb_din,
	output logic [phy_ctl_pkg::LB_DAT-1:0] lb_dout,
	output logic lb_vld,
	input logic [phy_ctl_pkg::PIO_IN_W-1:0] pio_in,
	output logic [phy_ctl_pkg::PIO_OUT_W-1:0] pio_out
);

	import phy_ctl_pkg::*;

	// LMMI fabric
	logic [LMMI_PORTS-1:0] lmmi_req;
	logic [LMMI_PORTS-1:0] lmmi_dir;
	logic [LMMI_ADR-1:0] lmmi_adr;
	logic [LMMI_DAT-1:0] lmmi_wdat;
	logic [LMMI_PORTS-1:0] lmmi_rdy;
	logic [LMMI_PORTS-1:0] lmmi_vld;
	logic [LMMI_PORTS*LMMI_DAT-1:0] lmmi_rdat;

	// Collector results
	logic xfer_done;
	logic rd_done;
	logic [LMMI_DAT-1:0] rd_dat;

	phy_ctl_regs i_regs (
		.CLK_IN(CLK_IN),
		.RST_IN(RST_IN),
		.lb_adr(lb_adr),
		.lb_wr(lb_wr),
		.lb_rd(lb_rd),
		.lb_din(lb_din),
		.lb_dout(lb_dout),
		.lb_vld(lb_vld),
		.xfer_done(xfer_done),
		.rd_done(rd_done),
		.rd_dat(rd_dat),
		.lmmi_req(lmmi_req),
		.lmmi_dir(lmmi_dir),
		.lmmi_adr(lmmi_adr),
		.lmmi_wdat(lmmi_wdat),
		.pio_in(pio_in),
		.pio_out(pio_out)
	);

	// Ready delay grows with the port index
	for (genvar i = 0; i < LMMI_PORTS; i++)
	begin : gen_port
		lmmi_reg_port #(
			.WAIT_CYCLES(i + 2)
		) i_port (
			.CLK_IN(CLK_IN),
			.RST_IN(RST_IN),
			.req(lmmi_req[i]),
			.dir(lmmi_dir[i]),
			.adr(lmmi_adr),
			.wdat(lmmi_wdat),
			.rdy(lmmi_rdy[i]),
			.vld(lmmi_vld[i]),
			.rdat(lmmi_rdat[i*LMMI_DAT +: LMMI_DAT])
		);
	end

	lmmi_rd_collect i_collect (
		.CLK_IN(CLK_IN),
		.RST_IN(RST_IN),
		.vld(lmmi_vld),
		.rdat(lmmi_rdat),
		.rdy(lmmi_rdy),
		.rd_dat(rd_dat),
		.rd_done(rd_done),
		.xfer_done(xfer_done)
	);

endmodule

// File: lmmi/lmmi_rd_collect.sv
`timescale 1ns/1ps

module lmmi_rd_collect (
	input logic CLK_IN,
	input logic RST_IN,
	input logic [phy_ctl_pkg::LMMI_PORTS-1:0] vld,
	// Read bytes, port 0 in the low byte
	input logic [phy_ctl_pkg::LMMI_PORTS*phy_ctl_pkg::LMMI_DAT-1:0] rdat,
	input logic [phy_ctl_pkg::LMMI_PORTS-1:0] rdy,
	output logic [phy_ctl_pkg::LMMI_DAT-1:0] rd_dat,
	output logic rd_done,
	output logic xfer_done
);

	import phy_ctl_pkg::*;

	// Valid history per port
	logic [LMMI_PORTS-1:0] vld_q;
	logic [LMMI_PORTS-1:0] vld_re;

	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			vld_q <= '0;
		else
			vld_q <= vld;
	end

	// Rising edges
	assign vld_re = vld & ~vld_q;

	// Any new read result
	assign rd_done = |vld_re;

	// Capture byte of the port with the edge
	// Only one port is active at a time
	always_ff @(posedge CLK_IN)
	begin
		for (int i = 0; i < LMMI_PORTS; i++)
		begin
			if (vld_re[i])
				rd_dat <= rdat[i*LMMI_DAT +: LMMI_DAT];
		end
	end

	// Transfer ends on any port ready
	assign xfer_done = |rdy;

endmodule

// File: lmmi/lmmi_reg_port.sv
`timescale 1ns/1ps

module lmmi_reg_port #(
	parameter int WAIT_CYCLES = 2
) (
	input logic CLK_IN,
	input logic RST_IN,
	input logic req,
	input logic dir,
	input logic [phy_ctl_pkg::LMMI_ADR-1:0] adr,
	input logic [phy_ctl_pkg::LMMI_DAT-1:0] wdat,
	output logic rdy,
	output logic vld,
	output logic [phy_ctl_pkg::LMMI_DAT-1:0] rdat
);

	import phy_ctl_pkg::*;

	// Wait counter width
	localparam int CNT_W = $clog2(WAIT_CYCLES) + 1;

	// Byte wide register space, contents unknown until written
	logic [LMMI_DAT-1:0] mem [0:(1 << LMMI_ADR)-1];
	logic [CNT_W-1:0] cnt;
	logic wait_end;

	// Last wait cycle of this request
	assign wait_end = req && !rdy && (cnt == CNT_W'(WAIT_CYCLES - 1));

	// Count while req is held, park during the ready pulse
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			cnt <= '0;
		else if (!req || rdy || wait_end)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Ready is a single cycle pulse
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			rdy <= 1'b0;
		else
			rdy <= wait_end;
	end

	// Read valid trails ready by one cycle
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			vld <= 1'b0;
		else
			vld <= rdy && !dir;
	end

	// Write lands with the ready pulse
	always_ff @(posedge CLK_IN)
	begin
		if (wait_end && dir)
			mem[adr] <= wdat;
	end

	// Read byte presented with vld
	always_ff @(posedge CLK_IN)
	begin
		if (rdy && !dir)
			rdat <= mem[adr];
	end

endmodule

// File: design/phy_ctl_regs.sv
`timescale 1ns/1ps

module phy_ctl_regs (
	input logic CLK_IN,
	input logic RST_IN,

	// Local bus
	input logic [phy_ctl_pkg::LB_ADR-1:0] lb_adr,
	input logic lb_wr,
	input logic lb_rd,
	input logic [phy_ctl_pkg::LB_DAT-1:0] lb_din,
	output logic [phy_ctl_pkg::LB_DAT-1:0] lb_dout,
	output logic lb_vld,

	// Transfer status from the collector
	input logic xfer_done,
	input logic rd_done,
	input logic [phy_ctl_pkg::LMMI_DAT-1:0] rd_dat,

	// LMMI command side
	output logic [phy_ctl_pkg::LMMI_PORTS-1:0] lmmi_req,
	output logic [phy_ctl_pkg::LMMI_PORTS-1:0] lmmi_dir,
	output logic [phy_ctl_pkg::LMMI_ADR-1:0] lmmi_adr,
	output logic [phy_ctl_pkg::LMMI_DAT-1:0] lmmi_wdat,

	// Parallel IO
	input logic [phy_ctl_pkg::PIO_IN_W-1:0] pio_in,
	output logic [phy_ctl_pkg::PIO_OUT_W-1:0] pio_out
);

	import phy_ctl_pkg::*;

	// Registered bus inputs
	logic [LB_ADR-1:0] lb_adr_q;
	logic lb_wr_q;
	logic lb_rd_q;
	logic [LB_DAT-1:0] lb_din_q;

	// Write strobes
	logic wr_ctl;
	logic wr_sta;
	logic wr_lmmi;
	logic wr_pio_set;
	logic wr_pio_clr;
	logic wr_pio_out;
	logic wr_pio_msk;

	logic [CTL_RD:0] ctl_r;
	logic ctl_wr;
	logic ctl_rd;
	logic busy;
	logic sta_rdy;
	logic [STA_RDY:0] sta_r;

	// Command fields
	logic [PORT_W-1:0] cmd_port;
	logic [LMMI_ADR-1:0] cmd_adr;
	logic [LMMI_DAT-1:0] cmd_dat;

	logic [PIO_IN_W-1:0] pio_in_q;
	logic [PIO_OUT_W-1:0] pio_msk;
	logic [PIO_OUT_W-1:0] pio_dout;

	// Registered bus strobes
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
		begin
			lb_wr_q <= 1'b0;
			lb_rd_q <= 1'b0;
		end
		else
		begin
			lb_wr_q <= lb_wr;
			lb_rd_q <= lb_rd;
		end
	end

	always_ff @(posedge CLK_IN)
	begin
		lb_adr_q <= lb_adr;
		lb_din_q <= lb_din;
		// PIO input sampled every cycle
		pio_in_q <= pio_in;
	end

	// Write address decode
	always_comb
	begin
		wr_ctl = 1'b0;
		wr_sta = 1'b0;
		wr_lmmi = 1'b0;
		wr_pio_set = 1'b0;
		wr_pio_clr = 1'b0;
		wr_pio_out = 1'b0;
		wr_pio_msk = 1'b0;
		if (lb_wr_q)
		begin
			case (lb_adr_q)
				REG_CTL: wr_ctl = 1'b1;
				REG_STA: wr_sta = 1'b1;
				REG_LMMI: wr_lmmi = 1'b1;
				REG_PIO_SET: wr_pio_set = 1'b1;
				REG_PIO_CLR: wr_pio_clr = 1'b1;
				REG_PIO_OUT: wr_pio_out = 1'b1;
				REG_PIO_MSK: wr_pio_msk = 1'b1;
				default: ;
			endcase
		end
	end

	// Read mux without side effects
	always_comb
	begin
		lb_dout = '0;
		case (lb_adr_q)
			REG_CTL: lb_dout[CTL_RD:0] = ctl_r;
			REG_STA: lb_dout[STA_RDY:0] = sta_r;
			REG_PIO_IN: lb_dout[PIO_IN_W-1:0] = pio_in_q;
			// Everything else shows the last LMMI read byte
			default: lb_dout[LMMI_DAT-1:0] = rd_dat;
		endcase
	end

	// Data goes with the registered read strobe
	assign lb_vld = lb_rd_q;

	// Control flags live for one cycle
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			ctl_r <= '0;
		else if (wr_ctl)
			ctl_r <= lb_din_q[CTL_RD:0];
		else
			ctl_r <= '0;
	end

	assign ctl_wr = ctl_r[CTL_WR];
	assign ctl_rd = ctl_r[CTL_RD];

	// Busy from command start until ready
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			busy <= 1'b0;
		else if (ctl_wr || ctl_rd)
			busy <= 1'b1;
		else if (xfer_done)
			busy <= 1'b0;
	end

	// Read ready cleared by writing one
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			sta_rdy <= 1'b0;
		else if (wr_sta && lb_din_q[STA_RDY])
			sta_rdy <= 1'b0;
		else if (rd_done)
			sta_rdy <= 1'b1;
	end

	always_comb
	begin
		sta_r[STA_BUSY] = busy;
		sta_r[STA_RDY] = sta_rdy;
	end

	// Port select for req and dir
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			cmd_port <= '0;
		else if (wr_lmmi)
			cmd_port <= lb_din_q[CMD_PORT_LSB +: PORT_W];
	end

	always_ff @(posedge CLK_IN)
	begin
		if (wr_lmmi)
		begin
			cmd_adr <= lb_din_q[CMD_ADR_LSB +: LMMI_ADR];
			cmd_dat <= lb_din_q[CMD_DAT_LSB +: LMMI_DAT];
		end
	end

	// Address and write data shared by all ports
	assign lmmi_adr = cmd_adr;
	assign lmmi_wdat = cmd_dat;

	// Request and direction on the selected port only
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
		begin
			lmmi_req <= '0;
			lmmi_dir <= '0;
		end
		else
		begin
			for (int i = 0; i < LMMI_PORTS; i++)
			begin
				if (cmd_port == PORT_W'(i))
				begin
					if (ctl_wr || ctl_rd)
					begin
						lmmi_req[i] <= 1'b1;
						// 1 is write
						lmmi_dir[i] <= ctl_wr;
					end
					// Only this port can be ready
					else if (xfer_done)
					begin
						lmmi_req[i] <= 1'b0;
						lmmi_dir[i] <= 1'b0;
					end
				end
				else
				begin
					lmmi_req[i] <= 1'b0;
					lmmi_dir[i] <= 1'b0;
				end
			end
		end
	end

	// Mask back to all ones after a masked write
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			pio_msk <= '0;
		else if (wr_pio_msk)
			pio_msk <= lb_din_q[PIO_OUT_W-1:0];
		else if (wr_pio_out)
			pio_msk <= '1;
	end

	// Per bit set, clear and masked write
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			pio_dout <= '0;
		else
		begin
			for (int b = 0; b < PIO_OUT_W; b++)
			begin
				if (wr_pio_set && lb_din_q[b])
					pio_dout[b] <= 1'b1;
				else if (wr_pio_clr && lb_din_q[b])
					pio_dout[b] <= 1'b0;
				else if (wr_pio_out && pio_msk[b])
					pio_dout[b] <= lb_din_q[b];
			end
		end
	end

	assign pio_out = pio_dout;

endmodule

// File: common/phy_ctl_pkg.sv
package phy_ctl_pkg;

	// LMMI port array
	localparam int LMMI_PORTS = 4;
	// Port index width
	localparam int PORT_W = 2;
	// LMMI address and data widths
	localparam int LMMI_ADR = 9;
	localparam int LMMI_DAT = 8;

	// Parallel IO widths
	localparam int PIO_IN_W = 8;
	localparam int PIO_OUT_W = 8;

	// Local bus widths
	localparam int LB_ADR = 4;
	localparam int LB_DAT = 32;

	// Register map
	localparam logic [LB_ADR-1:0] REG_CTL = 4'd0;
	localparam logic [LB_ADR-1:0] REG_STA = 4'd1;
	// Command word, reads give back the captured LMMI byte
	localparam logic [LB_ADR-1:0] REG_LMMI = 4'd2;
	localparam logic [LB_ADR-1:0] REG_PIO_IN = 4'd3;
	localparam logic [LB_ADR-1:0] REG_PIO_SET = 4'd4;
	localparam logic [LB_ADR-1:0] REG_PIO_CLR = 4'd5;
	localparam logic [LB_ADR-1:0] REG_PIO_OUT = 4'd6;
	localparam logic [LB_ADR-1:0] REG_PIO_MSK = 4'd7;

	// Control bits, both self clearing
	localparam int CTL_WR = 0;
	localparam int CTL_RD = 1;

	// Status bits
	localparam int STA_BUSY = 0;
	// Read data ready, write one to clear
	localparam int STA_RDY = 1;

	// LMMI command word layout
	localparam int CMD_PORT_LSB = 0;
	localparam int CMD_ADR_LSB = 2;
	localparam int CMD_DAT_LSB = 11;

endpackage
